// File: rtl/merge_sort_top.sv
`timescale 1ns/100ps
`include "sort_config.svh"

module merge_sort_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  logic              sort_num,
    input  sort_pkg::record_t data_in  [0:`SORT_RECORDS-1],
    output sort_pkg::record_t data_out [0:`SORT_RECORDS-1],
    output logic              sorted
);

    localparam int PAIRS = `SORT_RECORDS / 2;
    localparam int QUADS = `SORT_RECORDS / 4;

    record_link_if link2 [PAIRS] ();
    record_link_if link4 [QUADS] ();
    record_link_if link8 ();

    ////////////////////////////////////////////////////////////
    // Pair stage
    ////////////////////////////////////////////////////////////
    for (genvar g = 0; g < PAIRS; g++) begin : g_pair
        pair_sorter u_pair_sorter (
            .clk   (clk),
            .rst_n (rst_n),
            .start (start),
            .order (sort_num),
            .rec_a (data_in[2*g]),
            .rec_b (data_in[2*g+1]),
            .out   (link2[g])
        );

        record_fifo #(.DEPTH(2)) u_fifo2 (
            .clk   (clk),
            .rst_n (rst_n),
            .link  (link2[g])
        );
    end

    ////////////////////////////////////////////////////////////
    // Runs of four
    ////////////////////////////////////////////////////////////
    for (genvar m = 0; m < QUADS; m++) begin : g_quad
        merge_unit #(.RUN_LEN(2)) u_merge4 (
            .clk   (clk),
            .rst_n (rst_n),
            .order (sort_num),
            .left  (link2[2*m]),
            .right (link2[2*m+1]),
            .out   (link4[m])
        );

        record_fifo #(.DEPTH(4)) u_fifo4 (
            .clk   (clk),
            .rst_n (rst_n),
            .link  (link4[m])
        );
    end

    // Final run of eight
    merge_unit #(.RUN_LEN(4)) u_merge8 (
        .clk   (clk),
        .rst_n (rst_n),
        .order (sort_num),
        .left  (link4[0]),
        .right (link4[1]),
        .out   (link8)
    );

    record_fifo #(.DEPTH(8)) u_fifo8 (
        .clk   (clk),
        .rst_n (rst_n),
        .link  (link8)
    );

    result_collector u_collector (
        .clk      (clk),
        .rst_n    (rst_n),
        .in       (link8),
        .data_out (data_out),
        .sorted   (sorted)
    );

endmodule

// File: rtl/merge_unit.sv
`timescale 1ns/100ps

module merge_unit #(
    parameter int RUN_LEN = 2
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              order,
    record_link_if.consumer   left,
    record_link_if.consumer   right,
    record_link_if.producer   out
);

    sort_pkg::run_cnt_t l_cnt_q;
    sort_pkg::run_cnt_t r_cnt_q;
    logic               l_done;
    logic               r_done;
    sort_pkg::byte_t    l_key;
    sort_pkg::byte_t    r_key;
    logic               l_first;
    logic               take_left;
    logic               stall;
    logic               do_read;
    logic               last_read;
    sort_pkg::record_t  out_q;
    logic               wr_q;

    assign l_done = (l_cnt_q == sort_pkg::run_cnt_t'(RUN_LEN));
    assign r_done = (r_cnt_q == sort_pkg::run_cnt_t'(RUN_LEN));

    assign l_key = left.r_data[$bits(sort_pkg::record_t)-1 -: $bits(sort_pkg::byte_t)];
    assign r_key = right.r_data[$bits(sort_pkg::record_t)-1 -: $bits(sort_pkg::byte_t)];

    // Left wins ties so equal keys stay in input order
    assign l_first = order ? (l_key >= r_key) : (l_key <= r_key);

    assign take_left = r_done || (!l_done && l_first);

    ////////////////////////////////////////////////////////////
    // Read decision
    ////////////////////////////////////////////////////////////
    // Need both heads unless one run is already used up
    assign stall = out.full
                || (!l_done && left.empty)
                || (!r_done && right.empty);

    assign do_read  = !stall;
    assign left.rd  = do_read && take_left;
    assign right.rd = do_read && !take_left;

    // Final record of the pair of runs
    assign last_read = (int'(l_cnt_q) + int'(r_cnt_q) == 2 * RUN_LEN - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            l_cnt_q <= '0;
            r_cnt_q <= '0;
        end else if (do_read) begin
            if (last_read) begin
                l_cnt_q <= '0;
                r_cnt_q <= '0;
            end else if (take_left) begin
                l_cnt_q <= l_cnt_q + 1'b1;
            end else begin
                r_cnt_q <= r_cnt_q + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (do_read) begin
            out_q <= take_left ? left.r_data : right.r_data;
        end
    end

    // Pending write holds while the output FIFO is full
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_q <= 1'b0;
        end else if (do_read) begin
            wr_q <= 1'b1;
        end else if (!out.full) begin
            wr_q <= 1'b0;
        end
    end

    assign out.wr     = wr_q && !out.full;
    assign out.w_data = out_q;

endmodule

// File: rtl/pair_sorter.sv
`timescale 1ns/100ps

module pair_sorter (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  logic              order,
    input  sort_pkg::record_t rec_a,
    input  sort_pkg::record_t rec_b,
    record_link_if.producer   out
);

    sort_pkg::byte_t   key_a;
    sort_pkg::byte_t   key_b;
    logic              a_first;
    sort_pkg::record_t first_q;
    sort_pkg::record_t second_q;
    logic              wr_q;
    logic              sel_second_q;

    assign key_a = rec_a[$bits(sort_pkg::record_t)-1 -: $bits(sort_pkg::byte_t)];
    assign key_b = rec_b[$bits(sort_pkg::record_t)-1 -: $bits(sort_pkg::byte_t)];

    // Ties keep rec_a in front
    assign a_first = order ? (key_a >= key_b) : (key_a <= key_b);

    always_ff @(posedge clk) begin
        if (start) begin
            first_q  <= a_first ? rec_a : rec_b;
            second_q <= a_first ? rec_b : rec_a;
        end
    end

    // Two writes after start, held off while the FIFO is full
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_q         <= 1'b0;
            sel_second_q <= 1'b0;
        end else if (start) begin
            wr_q         <= 1'b1;
            sel_second_q <= 1'b0;
        end else if (wr_q && !out.full) begin
            if (sel_second_q) begin
                wr_q <= 1'b0;
            end
            sel_second_q <= !sel_second_q;
        end
    end

    assign out.wr     = wr_q && !out.full;
    assign out.w_data = sel_second_q ? second_q : first_q;

endmodule

// File: rtl/record_fifo.sv
`timescale 1ns/100ps

module record_fifo #(
    parameter int DEPTH = 2
) (
    input  logic          clk,
    input  logic          rst_n,
    record_link_if.store  link
);

    localparam int AW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);

    sort_pkg::record_t mem [DEPTH];
    logic [AW-1:0]     wr_ptr;
    logic [AW-1:0]     rd_ptr;
    logic [CW-1:0]     count;
    logic              do_wr;
    logic              do_rd;

    assign do_wr = link.wr && !link.full;
    assign do_rd = link.rd && !link.empty;

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= link.w_data;
        end
    end

    ////////////////////////////////////////////////////////////
    // Pointers and fill level
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Show-ahead head record
    assign link.r_data = mem[rd_ptr];
    assign link.empty  = (count == '0);
    assign link.full   = (count == CW'(DEPTH));

endmodule

// File: rtl/record_link_if.sv
`timescale 1ns/100ps

interface record_link_if;

    // Write side
    logic              wr;
    sort_pkg::record_t w_data;
    logic              full;

    // Read side, head record shown while not empty
    logic              rd;
    sort_pkg::record_t r_data;
    logic              empty;

    modport producer (output wr, output w_data, input full);

    modport store (
        input  wr,
        input  w_data,
        output full,
        input  rd,
        output r_data,
        output empty
    );

    modport consumer (output rd, input r_data, input empty);

endinterface

// File: rtl/result_collector.sv
`timescale 1ns/100ps
`include "sort_config.svh"

module result_collector (
    input  logic              clk,
    input  logic              rst_n,
    record_link_if.consumer   in,
    output sort_pkg::record_t data_out [0:`SORT_RECORDS-1],
    output logic              sorted
);

    sort_pkg::collect_state_t state_q;
    sort_pkg::rec_idx_t       pos_q;
    logic                     take;

    // Drain as soon as a record shows up
    assign take  = !in.empty;
    assign in.rd = take;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= sort_pkg::st_idle;
            pos_q   <= '0;
            sorted  <= 1'b0;
            for (int i = 0; i < `SORT_RECORDS; i++) begin
                data_out[i] <= '0;
            end
        end else begin
            sorted <= 1'b0;
            if (take) begin
                data_out[pos_q] <= in.r_data;
            end
            case (state_q)
                sort_pkg::st_idle: begin
                    if (take) begin
                        pos_q   <= pos_q + 1'b1;
                        state_q <= sort_pkg::st_draining;
                    end
                end
                sort_pkg::st_draining: begin
                    if (take) begin
                        if (pos_q == sort_pkg::rec_idx_t'(`SORT_RECORDS - 1)) begin
                            // Last record stored, one-cycle done pulse
                            sorted  <= 1'b1;
                            pos_q   <= '0;
                            state_q <= sort_pkg::st_idle;
                        end else begin
                            pos_q <= pos_q + 1'b1;
                        end
                    end
                end
                default: state_q <= sort_pkg::st_idle;
            endcase
        end
    end

endmodule

// File: rtl/sort_config.svh
`ifndef SORT_CONFIG_SVH
`define SORT_CONFIG_SVH

// Record layout
`define SORT_COLUMNS 3
`define SORT_BYTE_W 8

// Batch size
`define SORT_RECORDS 8

`endif

// File: rtl/sort_pkg.sv
`include "sort_config.svh"

package sort_pkg;

    // One column of a record
    typedef logic [`SORT_BYTE_W-1:0] byte_t;

    // Column 0 sits in the top byte and is the sort key
    typedef logic [`SORT_COLUMNS*`SORT_BYTE_W-1:0] record_t;

    // Position inside the batch
    typedef logic [$clog2(`SORT_RECORDS)-1:0] rec_idx_t;

    // Records taken from one merge input, up to the longest run
    typedef logic [$clog2(`SORT_RECORDS):0] run_cnt_t;

    typedef enum logic {
        st_idle,
        st_draining
    } collect_state_t;

endpackage

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the merge sorter testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f verilog.f \
    --top-module merge_sort_tb -Mdir obj_dir -o merge_sort_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/merge_sort_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "=== PASS ===" "$LOG"; then
    exit 0
fi
exit 1

// File: tests/merge_sort_tb.sv
`timescale 1ns/100ps
`include "sort_config.svh"

module merge_sort_tb;

    localparam int N          = `SORT_RECORDS;
    localparam int WAIT_LIMIT = 200;

    logic              clk;
    logic              rst_n;
    logic              start;
    logic              sort_num;
    sort_pkg::record_t data_in  [0:N-1];
    sort_pkg::record_t data_out [0:N-1];
    logic              sorted;

    // Batch under test and its reference order
    sort_pkg::record_t stim     [0:N-1];
    sort_pkg::record_t expected [0:N-1];
    int                mismatches;
    int                failures;

    merge_sort_top dut0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .sort_num (sort_num),
        .data_in  (data_in),
        .data_out (data_out),
        .sorted   (sorted)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////
    function automatic sort_pkg::byte_t key_of(sort_pkg::record_t r);
        return r[$bits(sort_pkg::record_t)-1 -: $bits(sort_pkg::byte_t)];
    endfunction

    function automatic sort_pkg::record_t make_record(sort_pkg::byte_t k,
                                                      sort_pkg::byte_t c1,
                                                      sort_pkg::byte_t c2);
        return {k, c1, c2};
    endfunction

    // Strict compare keeps equal keys in input order
    function automatic logic goes_after(sort_pkg::record_t a, sort_pkg::record_t b,
                                        logic desc);
        return desc ? (key_of(a) < key_of(b)) : (key_of(a) > key_of(b));
    endfunction

    task automatic build_reference(input logic desc);
        sort_pkg::record_t cur;
        int                j;
        for (int i = 0; i < N; i++) begin
            expected[i] = stim[i];
        end
        for (int i = 1; i < N; i++) begin
            cur = expected[i];
            j   = i - 1;
            while (j >= 0 && goes_after(expected[j], cur, desc)) begin
                expected[j+1] = expected[j];
                j--;
            end
            expected[j+1] = cur;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////
    task automatic check_record(input int idx, input sort_pkg::record_t exp,
                                input sort_pkg::record_t act);
        if (act !== exp) begin
            $display("error: data_out[%0d] expected %h got %h", idx, exp, act);
            mismatches++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("error: %s expected %h got %h", name, exp, act);
            mismatches++;
        end
    endtask

    task automatic check_cleared();
        for (int i = 0; i < N; i++) begin
            check_record(i, '0, data_out[i]);
        end
        check_flag("sorted", 1'b0, sorted);
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////
    task automatic fill_random_distinct();
        bit              used [256];
        sort_pkg::byte_t k;
        for (int i = 0; i < 256; i++) begin
            used[i] = 1'b0;
        end
        for (int i = 0; i < N; i++) begin
            k = sort_pkg::byte_t'($urandom);
            while (used[k]) begin
                k = k + 8'd1;
            end
            used[k] = 1'b1;
            stim[i] = make_record(k, sort_pkg::byte_t'($urandom), sort_pkg::byte_t'($urandom));
        end
    endtask

    task automatic fill_random();
        for (int i = 0; i < N; i++) begin
            stim[i] = sort_pkg::record_t'($urandom);
        end
    endtask

    // Three keys with ties inside pairs and across both merge stages
    // Column 1 holds the input position
    task automatic fill_with_duplicates();
        for (int i = 0; i < N; i++) begin
            stim[i] = make_record(sort_pkg::byte_t'(32'h20 * (((N - 1 - i) * 3) / 8) + 32'h11),
                                  sort_pkg::byte_t'(i), sort_pkg::byte_t'($urandom));
        end
    endtask

    // Called a small delay after a rising edge
    task automatic launch_batch(input logic desc);
        for (int i = 0; i < N; i++) begin
            data_in[i] = stim[i];
        end
        sort_num = desc;
        start    = 1'b1;
        @(posedge clk);
        #1 start = 1'b0;
    endtask

    task automatic wait_sorted(output bit seen);
        int n;
        seen = 1'b0;
        n    = 0;
        while (!seen && n < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            if (sorted === 1'b1) begin
                seen = 1'b1;
            end
            n++;
        end
        if (!seen) begin
            $display("timeout: sorted did not rise within %0d cycles", WAIT_LIMIT);
            failures++;
        end
    endtask

    task automatic run_batch(input logic desc);
        bit seen;
        build_reference(desc);
        launch_batch(desc);
        wait_sorted(seen);
        if (seen) begin
            for (int i = 0; i < N; i++) begin
                check_record(i, expected[i], data_out[i]);
            end
        end
    endtask

    // No further sorted pulse may appear
    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #1;
            check_flag("sorted", 1'b0, sorted);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////
    task automatic test_ascending_random();
        fill_random_distinct();
        run_batch(1'b0);
        expect_quiet(20);
    endtask

    task automatic test_descending_random();
        fill_random();
        run_batch(1'b1);
        expect_quiet(5);
    endtask

    task automatic test_stability();
        fill_with_duplicates();
        run_batch(1'b0);
        run_batch(1'b1);
        expect_quiet(5);
    endtask

    // Second batch starts in the cycle where sorted is seen
    task automatic test_back_to_back();
        for (int i = 0; i < N; i++) begin
            stim[i] = make_record(sort_pkg::byte_t'(i * 16 + 3), sort_pkg::byte_t'(i),
                                  sort_pkg::byte_t'($urandom));
        end
        run_batch(1'b0);
        for (int i = 0; i < N; i++) begin
            stim[i] = make_record(sort_pkg::byte_t'((N - 1 - i) * 16 + 3),
                                  sort_pkg::byte_t'(i), sort_pkg::byte_t'($urandom));
        end
        run_batch(1'b0);
        expect_quiet(5);
    endtask

    task automatic test_reset_mid_batch();
        fill_random();
        launch_batch(1'b0);
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
        check_cleared();
        expect_quiet(30);
        fill_random_distinct();
        run_batch(1'b1);
    endtask

    initial begin
        void'($urandom(32'h4921_648e));
        rst_n      = 1'b0;
        start      = 1'b0;
        sort_num   = 1'b0;
        mismatches = 0;
        failures   = 0;
        for (int i = 0; i < N; i++) begin
            data_in[i] = '0;
        end
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;

        check_cleared();
        test_ascending_random();
        test_descending_random();
        test_stability();
        test_back_to_back();
        test_reset_mid_batch();

        $display("mismatches: %0d, other failures: %0d", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+rtl
rtl/sort_pkg.sv
rtl/record_link_if.sv
rtl/pair_sorter.sv
rtl/record_fifo.sv
rtl/merge_unit.sv
rtl/result_collector.sv
rtl/merge_sort_top.sv
tests/merge_sort_tb.sv
